// File: Bender.yml
package:
  name: ooo_core

sources:
  - src/ooo_pkg.sv
  - src/alu_unit.sv
  - src/branch_unit.sv
  - src/rob.sv
  - src/ooo_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/ooo_core_tb.sv

// File: list.f
src/ooo_pkg.sv
src/alu_unit.sv
src/branch_unit.sv
src/rob.sv
src/ooo_core.sv
tests/tb_clock_gen.sv
tests/ooo_core_tb.sv

// File: src/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      squash,
    input  ooo_pkg::issue_packet_t    issue,
    output ooo_pkg::complete_packet_t complete
);

    ooo_pkg::word_t    result;
    logic              valid_q;
    ooo_pkg::rob_tag_t tag_q;
    ooo_pkg::word_t    value_q;

    always_comb begin
        case (issue.op)
            ooo_pkg::OP_ADD: result = issue.src_a + issue.src_b;
            ooo_pkg::OP_SUB: result = issue.src_a - issue.src_b;
            ooo_pkg::OP_AND: result = issue.src_a & issue.src_b;
            ooo_pkg::OP_XOR: result = issue.src_a ^ issue.src_b;
            default:         result = '0;   // branches never routed here
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clock) begin
        tag_q   <= issue.tag;
        value_q <= result;
    end

    always_comb begin
        complete.valid  = valid_q;
        complete.tag    = tag_q;
        complete.value  = value_q;
        complete.taken  = 1'b0;   // not a branch
        complete.target = '0;
    end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      squash,
    input  ooo_pkg::issue_packet_t    issue,
    output ooo_pkg::complete_packet_t complete
);

    typedef struct packed {
        ooo_pkg::rob_tag_t tag;
        logic              taken;
        ooo_pkg::word_t    sum;    // pc + imm
        ooo_pkg::word_t    seq;    // pc + 4
    } br_stage_t;

    br_stage_t         s1_d;
    br_stage_t         s1_q;
    logic              s1_valid;
    logic              s2_valid;
    ooo_pkg::rob_tag_t s2_tag;
    logic              s2_taken;
    ooo_pkg::word_t    s2_target;

    // stage one: compare and form both candidate addresses
    always_comb begin
        s1_d.tag = issue.tag;
        case (issue.op)
            ooo_pkg::OP_BEQ: s1_d.taken = (issue.src_a == issue.src_b);
            ooo_pkg::OP_BNE: s1_d.taken = (issue.src_a != issue.src_b);
            default:         s1_d.taken = 1'b0;
        endcase
        s1_d.sum = issue.pc + issue.imm;
        s1_d.seq = issue.pc + 32'd4;
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    // stage two: pick the resolved next pc
    always_ff @(posedge clock) begin
        s1_q      <= s1_d;
        s2_tag    <= s1_q.tag;
        s2_taken  <= s1_q.taken;
        s2_target <= s1_q.taken ? s1_q.sum : s1_q.seq;
    end

    always_comb begin
        complete.valid  = s2_valid;
        complete.tag    = s2_tag;
        complete.value  = '0;        // no link register
        complete.taken  = s2_taken;
        complete.target = s2_target;
    end

endmodule

// File: src/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int ROB_SIZE = ooo_pkg::ROB_SIZE
) (
    input  logic                      clock,
    input  logic                      reset,
    input  ooo_pkg::dispatch_packet_t dispatch,
    output ooo_pkg::commit_packet_t   commit,
    output logic                      squash,
    output logic [$clog2(ROB_SIZE):0] credit_return
);

    ooo_pkg::issue_packet_t          alu_issue;
    ooo_pkg::issue_packet_t          br_issue;
    ooo_pkg::complete_packet_t [1:0] cdb;       // lane 0 alu, lane 1 branch

    rob #(
        .SIZE          (ROB_SIZE)
    ) u_rob (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .alu_issue     (alu_issue),
        .br_issue      (br_issue),
        .commit        (commit),
        .squash        (squash),
        .credit_return (credit_return)
    );

    alu_unit u_alu (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .issue    (alu_issue),
        .complete (cdb[0])
    );

    branch_unit u_branch (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .issue    (br_issue),
        .complete (cdb[1])
    );

endmodule

// File: src/ooo_pkg.sv
package ooo_pkg;

    localparam int ROB_SIZE  = 8;   // default depth, top level overrides
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int TAG_W     = $clog2(ROB_SIZE);

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arn_t;
    typedef logic [TAG_W-1:0]             rob_tag_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_BEQ = 3'd4,
        OP_BNE = 3'd5
    } opcode_e;

    // one operation from the producer
    typedef struct packed {
        logic    valid;
        opcode_e op;
        word_t   src_a;
        word_t   src_b;
        word_t   imm;          // branch offset
        arn_t    dest;
        word_t   pc;
        logic    pred_taken;
        word_t   pred_target;
    } dispatch_packet_t;

    // rob to execution unit
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        opcode_e  op;
        word_t    src_a;
        word_t    src_b;
        word_t    imm;
        word_t    pc;
    } issue_packet_t;

    // one completion bus lane
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        logic     taken;       // branches only
        word_t    target;      // branches only
    } complete_packet_t;

    // retired operation, oldest first
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        arn_t     dest;
        word_t    value;
        word_t    pc;
        logic     is_branch;
        logic     mispredict;
        word_t    next_pc;     // resolved target or pc+4
    } commit_packet_t;

endpackage

// File: src/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int SIZE = ooo_pkg::ROB_SIZE
) (
    input  logic                                clock,
    input  logic                                reset,
    input  ooo_pkg::dispatch_packet_t           dispatch,
    input  ooo_pkg::complete_packet_t [1:0]     cdb,
    output ooo_pkg::issue_packet_t              alu_issue,
    output ooo_pkg::issue_packet_t              br_issue,
    output ooo_pkg::commit_packet_t             commit,
    output logic                                squash,
    output logic [$clog2(SIZE):0]               credit_return
);

    localparam int IDX_W = $clog2(SIZE);
    localparam int CNT_W = IDX_W + 1;

    typedef struct packed {
        logic           executed;
        logic           is_branch;
        logic           mispredict;
        ooo_pkg::arn_t  dest;
        ooo_pkg::word_t value;
        ooo_pkg::word_t pc;
        logic           pred_taken;
        ooo_pkg::word_t pred_target;
        logic           res_taken;
        ooo_pkg::word_t res_target;
    } rob_entry_t;

    rob_entry_t       entries [SIZE];
    rob_entry_t       head_entry;
    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [CNT_W-1:0] count;             // occupancy
    logic             dispatch_is_branch;
    logic             alloc;
    logic [IDX_W-1:0] cdb_idx  [2];
    logic [1:0]       cdb_miss;          // per lane mispredict result

    function automatic logic [IDX_W-1:0] wrap_inc(input logic [IDX_W-1:0] ptr);
        if (ptr == IDX_W'(SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign dispatch_is_branch = (dispatch.op == ooo_pkg::OP_BEQ) ||
                                (dispatch.op == ooo_pkg::OP_BNE);
    assign alloc = dispatch.valid && !squash;   // wrong path op dropped on squash

    // route the new entry to its unit, tail is the tag
    always_comb begin
        alu_issue.valid = alloc && !dispatch_is_branch;
        alu_issue.tag   = ooo_pkg::rob_tag_t'(tail);
        alu_issue.op    = dispatch.op;
        alu_issue.src_a = dispatch.src_a;
        alu_issue.src_b = dispatch.src_b;
        alu_issue.imm   = dispatch.imm;
        alu_issue.pc    = dispatch.pc;
        br_issue        = alu_issue;
        br_issue.valid  = alloc && dispatch_is_branch;
    end

    assign head_entry = entries[head];

    always_comb begin
        commit.valid      = (count != '0) && head_entry.executed;
        commit.tag        = ooo_pkg::rob_tag_t'(head);
        commit.dest       = head_entry.dest;
        commit.value      = head_entry.value;
        commit.pc         = head_entry.pc;
        commit.is_branch  = head_entry.is_branch;
        commit.mispredict = head_entry.mispredict;
        commit.next_pc    = head_entry.res_taken ? head_entry.res_target
                                                 : head_entry.pc + 32'd4;
    end

    assign squash = commit.valid && head_entry.mispredict;

    // a squash frees every entry plus the dropped same cycle dispatch
    always_comb begin
        if (squash) begin
            credit_return = count + CNT_W'(dispatch.valid);
        end else begin
            credit_return = CNT_W'(commit.valid);
        end
    end

    // resolved vs predicted, target only matters when taken
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cdb_idx[i]  = IDX_W'(cdb[i].tag);
            cdb_miss[i] = entries[cdb_idx[i]].is_branch &&
                          ((cdb[i].taken != entries[cdb_idx[i]].pred_taken) ||
                           (cdb[i].taken && (cdb[i].target != entries[cdb_idx[i]].pred_target)));
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (commit.valid) begin
                head <= wrap_inc(head);
            end
            if (alloc) begin
                tail <= wrap_inc(tail);
            end
            count <= count + CNT_W'(alloc) - CNT_W'(commit.valid);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            entries[tail].executed    <= 1'b0;
            entries[tail].is_branch   <= dispatch_is_branch;
            entries[tail].mispredict  <= 1'b0;
            entries[tail].dest        <= dispatch.dest;
            entries[tail].pc          <= dispatch.pc;
            entries[tail].pred_taken  <= dispatch.pred_taken;
            entries[tail].pred_target <= dispatch.pred_target;
            entries[tail].res_taken   <= 1'b0;
        end
        for (int i = 0; i < 2; i++) begin
            if (cdb[i].valid && !squash) begin
                entries[cdb_idx[i]].executed   <= 1'b1;
                entries[cdb_idx[i]].value      <= cdb[i].value;
                entries[cdb_idx[i]].res_taken  <= cdb[i].taken;
                entries[cdb_idx[i]].res_target <= cdb[i].target;
                entries[cdb_idx[i]].mispredict <= cdb_miss[i];
            end
        end
    end

endmodule

// File: tests/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int ROB_SIZE    = 3;   // small depth so credits run out
    localparam int ALU_OPS     = 30;
    localparam int MIXED_OPS   = 40;
    localparam int MISS_OPS    = 40;
    localparam int STALL_OPS   = 20;
    localparam int TOTAL_OPS   = ALU_OPS + MIXED_OPS + MISS_OPS + STALL_OPS;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 100;

    typedef logic [$clog2(ROB_SIZE):0] credit_t;

    typedef enum int {
        MODE_ALU,
        MODE_MIXED,
        MODE_MISPREDICT,
        MODE_BRANCH
    } op_mode_e;

    logic                      clock;
    logic                      reset;
    ooo_pkg::dispatch_packet_t dispatch;
    ooo_pkg::commit_packet_t   commit;
    logic                      squash;
    credit_t                   credit_return;

    integer                  seed = 84;
    ooo_pkg::commit_packet_t expected_q [$];   // program order
    int                      credits;
    int                      alloc_ptr;         // follows the rob tail
    ooo_pkg::word_t          fetch_pc;
    string                   phase_name;
    logic                    dispatched_any;
    logic                    saw_zero_credit;
    int                      cycle_count    = 0;
    int                      commit_count   = 0;
    int                      squash_count   = 0;
    int                      mismatch_count = 0;
    int                      error_count    = 0;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (5)
    ) clock_gen (
        .clock (clock),
        .reset (reset)
    );

    ooo_core #(
        .ROB_SIZE      (ROB_SIZE)
    ) dut (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .commit        (commit),
        .squash        (squash),
        .credit_return (credit_return)
    );

    function automatic logic branch_taken(input ooo_pkg::dispatch_packet_t op);
        if (op.op == ooo_pkg::OP_BEQ) begin
            return op.src_a == op.src_b;
        end
        return op.src_a != op.src_b;
    endfunction

    // architectural result of one op, tag is filled in by the producer
    function automatic ooo_pkg::commit_packet_t ref_execute(input ooo_pkg::dispatch_packet_t op);
        ooo_pkg::commit_packet_t res;
        logic                    taken;
        res         = '0;
        res.valid   = 1'b1;
        res.dest    = op.dest;
        res.pc      = op.pc;
        res.next_pc = op.pc + 32'd4;
        case (op.op)
            ooo_pkg::OP_ADD: res.value = op.src_a + op.src_b;
            ooo_pkg::OP_SUB: res.value = op.src_a - op.src_b;
            ooo_pkg::OP_AND: res.value = op.src_a & op.src_b;
            ooo_pkg::OP_XOR: res.value = op.src_a ^ op.src_b;
            default: begin
                taken         = branch_taken(op);
                res.is_branch = 1'b1;
                if (taken) begin
                    res.next_pc = op.pc + op.imm;
                end
                // target only counts when the branch is taken
                res.mispredict = (taken != op.pred_taken) ||
                                 (taken && (op.pred_target != op.pc + op.imm));
            end
        endcase
        return res;
    endfunction

    function automatic ooo_pkg::dispatch_packet_t make_op(input op_mode_e mode);
        ooo_pkg::dispatch_packet_t op;
        logic                      is_br;
        int                        pick;
        op       = '0;
        op.valid = 1'b1;
        op.pc    = fetch_pc;
        op.dest  = ooo_pkg::arn_t'($random(seed));
        op.src_a = $random(seed);
        op.src_b = $random(seed);
        case (mode)
            MODE_ALU:        is_br = 1'b0;
            MODE_MIXED:      is_br = ({$random(seed)} % 3) == 0;
            MODE_MISPREDICT: is_br = ({$random(seed)} % 2) == 0;
            default:         is_br = 1'b1;
        endcase
        if (!is_br) begin
            op.op = ooo_pkg::opcode_e'({$random(seed)} % 4);
            return op;
        end
        op.op = ({$random(seed)} % 2 == 0) ? ooo_pkg::OP_BEQ : ooo_pkg::OP_BNE;
        if ({$random(seed)} % 2 == 0) begin
            op.src_b = op.src_a;   // roughly half of the compares equal
        end
        op.imm         = ({$random(seed)} % 32 + 2) * 4;
        op.pred_taken  = branch_taken(op);
        op.pred_target = op.pc + op.imm;
        if (mode == MODE_MISPREDICT) begin
            pick = {$random(seed)} % 4;
            if (pick == 0) begin
                op.pred_taken = !op.pred_taken;   // wrong direction
            end else if (pick == 1) begin
                op.pred_taken  = 1'b1;            // wrong target, or wrong direction
                op.pred_target = op.pc + op.imm + 32'd8;
            end
        end
        return op;
    endfunction

    function automatic string commit_str(input ooo_pkg::commit_packet_t c);
        return $sformatf("{tag %0d dest %0d value %h pc %h br %0b mp %0b next %h}",
                         c.tag, c.dest, c.value, c.pc, c.is_branch, c.mispredict, c.next_pc);
    endfunction

    task automatic check_commit(input string name, input ooo_pkg::commit_packet_t expected,
                                input ooo_pkg::commit_packet_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s commit: expected %s actual %s",
                     name, commit_str(expected), commit_str(actual));
            mismatch_count++;
        end
    endtask

    task automatic check_credits(input string name, input credit_t expected, input credit_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_squash(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s squash: expected %0b actual %0b", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // called on each rising edge, sees the values of the cycle just ended
    task automatic account_cycle();
        credits += int'(credit_return);
        if (credits < 0 || credits > ROB_SIZE) begin
            $display("ERROR: producer credits out of range (%0d) in %s", credits, phase_name);
            error_count++;
        end
        if (squash) begin
            check_credits({phase_name, " credits after squash"}, credit_t'(ROB_SIZE),
                          credit_t'(credits));
            fetch_pc  = commit.next_pc;   // refetch on the resolved path
            alloc_ptr = 0;
            squash_count++;
        end
    endtask

    task automatic drain();
        int idle;
        idle = 0;
        while (idle < 4) begin
            @(posedge clock);
            account_cycle();
            dispatch <= '0;
            idle = (expected_q.size() == 0) ? idle + 1 : 0;
        end
        check_credits({phase_name, " credits when idle"}, credit_t'(ROB_SIZE), credit_t'(credits));
    endtask

    task automatic run_phase(input string name, input op_mode_e mode, input int n_ops);
        ooo_pkg::dispatch_packet_t op;
        ooo_pkg::commit_packet_t   exp;
        int                        sent;
        phase_name      = name;
        saw_zero_credit = 1'b0;
        sent            = 0;
        while (sent < n_ops) begin
            @(posedge clock);
            account_cycle();
            if (credits > 0) begin
                op      = make_op(mode);
                exp     = ref_execute(op);
                exp.tag = ooo_pkg::rob_tag_t'(alloc_ptr);
                expected_q.push_back(exp);
                dispatch <= op;
                credits--;
                alloc_ptr = (alloc_ptr + 1) % ROB_SIZE;
                fetch_pc  = (exp.is_branch && op.pred_taken) ? op.pred_target
                                                             : op.pc + 32'd4;
                dispatched_any = 1'b1;
                sent++;
            end else begin
                dispatch <= '0;   // no credit, hold off
                saw_zero_credit = 1'b1;
            end
        end
        drain();
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures (%0d commits, %0d squashes)",
                 mismatch_count, error_count, commit_count, squash_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin : compare_commits
        ooo_pkg::commit_packet_t exp;
        logic                    exp_squash;
        if (!reset) begin
            exp_squash = 1'b0;
            if (!dispatched_any) begin
                if (commit.valid !== 1'b0 || squash !== 1'b0) begin
                    $display("ERROR: commit or squash active before the first dispatch");
                    error_count++;
                end
                check_credits("credit_return before first dispatch", '0, credit_return);
            end
            if (commit.valid === 1'b1) begin
                commit_count++;
                if (expected_q.size() == 0) begin
                    $display("ERROR: commit %s with no operation outstanding in %s",
                             commit_str(commit), phase_name);
                    error_count++;
                end else begin
                    exp = expected_q.pop_front();
                    check_commit(phase_name, exp, commit);
                    exp_squash = exp.mispredict;   // squash only with a mispredicted commit
                    if (exp.mispredict) begin
                        expected_q.delete();   // younger ops are wrong path
                    end
                end
            end
            check_squash(phase_name, exp_squash, squash);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles in %s, %0d commits still expected",
                     cycle_count, phase_name, expected_q.size());
            error_count++;
            finish_run();
        end
    end

    initial begin
        dispatch        <= '0;
        credits         = ROB_SIZE;
        alloc_ptr       = 0;
        fetch_pc        = 32'h0000_1000;
        phase_name      = "reset";
        dispatched_any  = 1'b0;
        saw_zero_credit = 1'b0;
        @(posedge clock);
        while (reset) begin
            @(posedge clock);
        end
        repeat (4) begin
            @(posedge clock);
            account_cycle();   // idle window after reset
        end
        run_phase("alu_in_order", MODE_ALU, ALU_OPS);
        run_phase("branch_predicted", MODE_MIXED, MIXED_OPS);
        if (squash_count != 0) begin
            $display("ERROR: squash seen while every branch was predicted correctly");
            error_count++;
        end
        run_phase("branch_mispredict", MODE_MISPREDICT, MISS_OPS);
        if (squash_count == 0) begin
            $display("ERROR: the mispredict phase never produced a squash");
            error_count++;
        end
        run_phase("full_stall", MODE_BRANCH, STALL_OPS);
        if (!saw_zero_credit) begin
            $display("ERROR: the producer never ran out of credits in full_stall");
            error_count++;
        end
        finish_run();
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;   // released on a rising edge
    end

endmodule
